/* hdl/desc_byte_framer.sv */
// Decode stage: frames descriptor bytes by bLength and issues indexed byte strobes
`timescale 1ns/100ps

module desc_byte_framer (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [7:0]                    data_in,
    input  logic                          data_valid,
    input  logic                          start_parse,
    output logic                          byte_strobe,
    output logic [7:0]                    byte_index,
    output logic [7:0]                    byte_data,
    output logic [7:0]                    desc_type,
    output logic                          first_byte,
    output logic                          last_byte,
    output logic                          abort,
    output desc_parser_pkg::frame_state_e parse_state
);

    // Input register stage
    logic [7:0] data_in_reg;
    logic       data_valid_reg;
    logic       start_parse_reg;

    desc_parser_pkg::frame_state_e state_q;
    desc_parser_pkg::frame_state_e state_d;

    // Stored bLength and the index of the next expected byte
    logic [7:0] desc_len;
    logic [7:0] byte_count;

    logic       take;
    logic       take_first;
    logic       take_last;
    logic       take_abort;
    logic       at_last;

    always_ff @(posedge clk) begin
        data_in_reg <= data_in;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            data_valid_reg  <= 1'b0;
            start_parse_reg <= 1'b0;
        end else begin
            data_valid_reg  <= data_valid;
            start_parse_reg <= start_parse;
        end
    end

    assign at_last = (byte_count == desc_len - 8'd1);

    always_comb begin
        state_d    = state_q;
        take       = 1'b0;
        take_first = 1'b0;
        take_last  = 1'b0;
        take_abort = 1'b0;
        case (state_q)
            // COMPLETE behaves like IDLE so a new start byte can follow at once
            desc_parser_pkg::IDLE, desc_parser_pkg::COMPLETE: begin
                state_d = desc_parser_pkg::IDLE;
                if (data_valid_reg && start_parse_reg) begin
                    take       = 1'b1;
                    take_first = 1'b1;
                    state_d    = desc_parser_pkg::LENGTH;
                end
            end
            desc_parser_pkg::LENGTH: begin
                if (data_valid_reg) begin
                    take = 1'b1;
                    if (desc_len < 8'd2) begin
                        take_abort = 1'b1;
                        state_d    = desc_parser_pkg::COMPLETE;
                    end else if (at_last) begin
                        take_last = 1'b1;
                        state_d   = desc_parser_pkg::COMPLETE;
                    end else begin
                        state_d = desc_parser_pkg::TYPE;
                    end
                end
            end
            desc_parser_pkg::TYPE, desc_parser_pkg::FIELDS: begin
                if (data_valid_reg) begin
                    take = 1'b1;
                    if (at_last) begin
                        take_last = 1'b1;
                        state_d   = desc_parser_pkg::COMPLETE;
                    end else begin
                        state_d = desc_parser_pkg::FIELDS;
                    end
                end
            end
            default: state_d = desc_parser_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state_q     <= desc_parser_pkg::IDLE;
            byte_count  <= 8'd0;
            byte_strobe <= 1'b0;
            first_byte  <= 1'b0;
            last_byte   <= 1'b0;
            abort       <= 1'b0;
        end else begin
            state_q     <= state_d;
            byte_strobe <= take;
            first_byte  <= take_first;
            last_byte   <= take_last;
            abort       <= take_abort;
            if (take) begin
                byte_count <= take_first ? 8'd1 : byte_count + 8'd1;
            end
        end
    end

    // Byte payload travels next to the strobe
    always_ff @(posedge clk) begin
        if (take) begin
            byte_data  <= data_in_reg;
            byte_index <= take_first ? 8'd0 : byte_count;
        end
        if (take_first) begin
            desc_len <= data_in_reg;
        end
        // The type byte is always index 1
        if (take && state_q == desc_parser_pkg::LENGTH) begin
            desc_type <= data_in_reg;
        end
    end

    assign parse_state = state_q;

endmodule

/* hdl/desc_parser_pkg.sv */
// Descriptor parser internal types: framer state codes and parse result codes
package desc_parser_pkg;

    // Width of the state code seen on parse_state
    localparam int STATE_W = 3;

    // Framer states, named after the byte most recently consumed
    typedef enum logic [STATE_W-1:0] {
        IDLE     = 3'd0,
        LENGTH   = 3'd1,
        TYPE     = 3'd2,
        FIELDS   = 3'd3,
        COMPLETE = 3'd4
    } frame_state_e;

    // Result of one framed descriptor
    typedef enum logic [1:0] {
        // Nothing parsed since reset
        STATUS_NONE       = 2'd0,
        // Device descriptor of the correct length
        STATUS_OK         = 2'd1,
        // Other descriptor type, consumed by its length
        STATUS_SKIPPED    = 2'd2,
        // bLength below 2, or a device descriptor of the wrong length
        STATUS_BAD_LENGTH = 2'd3
    } parse_status_e;

endpackage

/* hdl/desc_result_reg.sv */
// Result stage: holds the last good device information, pulses completion and counts descriptors
`timescale 1ns/100ps

module desc_result_reg #(
    parameter int COUNT_WIDTH = 8
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           done,
    input  desc_parser_pkg::parse_status_e status,
    input  logic [15:0]                    vendor_id_in,
    input  logic [15:0]                    product_id_in,
    input  logic [7:0]                     device_class_in,
    input  logic [7:0]                     max_packet_size_in,
    input  logic [7:0]                     num_configurations_in,
    output logic [15:0]                    vendor_id,
    output logic [15:0]                    product_id,
    output logic [7:0]                     device_class,
    output logic [7:0]                     max_packet_size,
    output logic [7:0]                     num_configurations,
    output logic                           device_info_valid,
    output logic                           parsing_complete,
    output desc_parser_pkg::parse_status_e parse_status,
    output logic [COUNT_WIDTH-1:0]         desc_count
);

    logic good;

    assign good = done && (status == desc_parser_pkg::STATUS_OK);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            vendor_id          <= 16'h0000;
            product_id         <= 16'h0000;
            device_class       <= 8'h00;
            max_packet_size    <= 8'h00;
            num_configurations <= 8'h00;
            device_info_valid  <= 1'b0;
            parsing_complete   <= 1'b0;
            parse_status       <= desc_parser_pkg::STATUS_NONE;
            desc_count         <= '0;
        end else begin
            parsing_complete <= done;
            if (done) begin
                parse_status <= status;
                // Counter wraps
                desc_count   <= desc_count + 1'b1;
            end
            // Skipped and bad descriptors leave earlier good data in place
            if (good) begin
                vendor_id          <= vendor_id_in;
                product_id         <= product_id_in;
                device_class       <= device_class_in;
                max_packet_size    <= max_packet_size_in;
                num_configurations <= num_configurations_in;
                device_info_valid  <= 1'b1;
            end
        end
    end

endmodule

/* hdl/device_field_extract.sv */
// Execute stage: captures device descriptor fields by byte index and grades each descriptor
`timescale 1ns/100ps

module device_field_extract (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           byte_strobe,
    input  logic [7:0]                     byte_index,
    input  logic [7:0]                     byte_data,
    input  logic [7:0]                     desc_type,
    input  logic                           first_byte,
    input  logic                           last_byte,
    input  logic                           abort,
    output logic                           done,
    output desc_parser_pkg::parse_status_e status,
    output logic [15:0]                    vendor_id,
    output logic [15:0]                    product_id,
    output logic [7:0]                     device_class,
    output logic [7:0]                     max_packet_size,
    output logic [7:0]                     num_configurations
);

    // bLength as declared by byte 0
    logic [7:0] decl_len;

    logic is_device;
    logic frame_end;

    desc_parser_pkg::parse_status_e status_d;

    assign is_device = (desc_type == usb_std_pkg::DEVICE);
    assign frame_end = byte_strobe && (last_byte || abort);

    // Grade the descriptor from its type and declared length
    always_comb begin
        if (abort) begin
            status_d = desc_parser_pkg::STATUS_BAD_LENGTH;
        end else if (is_device) begin
            if (decl_len == usb_std_pkg::DEVICE_DESC_LEN) begin
                status_d = desc_parser_pkg::STATUS_OK;
            end else begin
                status_d = desc_parser_pkg::STATUS_BAD_LENGTH;
            end
        end else begin
            status_d = desc_parser_pkg::STATUS_SKIPPED;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            done   <= 1'b0;
            status <= desc_parser_pkg::STATUS_NONE;
        end else begin
            done <= frame_end;
            if (frame_end) begin
                status <= status_d;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (byte_strobe && first_byte) begin
            decl_len <= byte_data;
        end
        // desc_type is stale on byte 0, but no field lives there
        if (byte_strobe && is_device) begin
            case (byte_index)
                usb_std_pkg::OFS_DEVICE_CLASS: device_class          <= byte_data;
                usb_std_pkg::OFS_MAX_PACKET:   max_packet_size       <= byte_data;
                usb_std_pkg::OFS_VENDOR_LO:    vendor_id[7:0]        <= byte_data;
                usb_std_pkg::OFS_VENDOR_HI:    vendor_id[15:8]       <= byte_data;
                usb_std_pkg::OFS_PRODUCT_LO:   product_id[7:0]       <= byte_data;
                usb_std_pkg::OFS_PRODUCT_HI:   product_id[15:8]      <= byte_data;
                usb_std_pkg::OFS_NUM_CONFIGS:  num_configurations    <= byte_data;
                default: ;
            endcase
        end
    end

endmodule

/* hdl/usb_desc_parser_top.sv */
// USB standard descriptor parser top: decode, execute and result stages in a row
`timescale 1ns/100ps

module usb_desc_parser_top #(
    parameter int COUNT_WIDTH = 8
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [7:0]                     data_in,
    input  logic                           data_valid,
    input  logic                           start_parse,
    output logic [15:0]                    vendor_id,
    output logic [15:0]                    product_id,
    output logic [7:0]                     device_class,
    output logic [7:0]                     max_packet_size,
    output logic [7:0]                     num_configurations,
    output logic                           device_info_valid,
    output logic                           parsing_complete,
    output desc_parser_pkg::parse_status_e parse_status,
    output logic [COUNT_WIDTH-1:0]         desc_count,
    output desc_parser_pkg::frame_state_e  parse_state
);

    // Framer to extractor
    logic       byte_strobe;
    logic [7:0] byte_index;
    logic [7:0] byte_data;
    logic [7:0] desc_type;
    logic       first_byte;
    logic       last_byte;
    logic       abort;

    // Extractor to result
    logic                           done;
    desc_parser_pkg::parse_status_e status;
    logic [15:0]                    ext_vendor_id;
    logic [15:0]                    ext_product_id;
    logic [7:0]                     ext_device_class;
    logic [7:0]                     ext_max_packet_size;
    logic [7:0]                     ext_num_configurations;

    desc_byte_framer framer_i (
        .clk         (clk),
        .reset       (reset),
        .data_in     (data_in),
        .data_valid  (data_valid),
        .start_parse (start_parse),
        .byte_strobe (byte_strobe),
        .byte_index  (byte_index),
        .byte_data   (byte_data),
        .desc_type   (desc_type),
        .first_byte  (first_byte),
        .last_byte   (last_byte),
        .abort       (abort),
        .parse_state (parse_state)
    );

    device_field_extract extract_i (
        .clk                (clk),
        .reset              (reset),
        .byte_strobe        (byte_strobe),
        .byte_index         (byte_index),
        .byte_data          (byte_data),
        .desc_type          (desc_type),
        .first_byte         (first_byte),
        .last_byte          (last_byte),
        .abort              (abort),
        .done               (done),
        .status             (status),
        .vendor_id          (ext_vendor_id),
        .product_id         (ext_product_id),
        .device_class       (ext_device_class),
        .max_packet_size    (ext_max_packet_size),
        .num_configurations (ext_num_configurations)
    );

    desc_result_reg #(
        .COUNT_WIDTH (COUNT_WIDTH)
    ) result_i (
        .clk                   (clk),
        .reset                 (reset),
        .done                  (done),
        .status                (status),
        .vendor_id_in          (ext_vendor_id),
        .product_id_in         (ext_product_id),
        .device_class_in       (ext_device_class),
        .max_packet_size_in    (ext_max_packet_size),
        .num_configurations_in (ext_num_configurations),
        .vendor_id             (vendor_id),
        .product_id            (product_id),
        .device_class          (device_class),
        .max_packet_size       (max_packet_size),
        .num_configurations    (num_configurations),
        .device_info_valid     (device_info_valid),
        .parsing_complete      (parsing_complete),
        .parse_status          (parse_status),
        .desc_count            (desc_count)
    );

endmodule

/* hdl/usb_std_pkg.sv */
// USB standard descriptor codes, device descriptor length and field byte offsets
package usb_std_pkg;

    // bDescriptorType codes from the USB 2.0 standard request chapter
    typedef enum logic [7:0] {
        DEVICE        = 8'd1,
        CONFIGURATION = 8'd2,
        STRING        = 8'd3,
        INTERFACE     = 8'd4,
        ENDPOINT      = 8'd5
    } desc_type_e;

    // Required bLength of a standard device descriptor
    localparam logic [7:0] DEVICE_DESC_LEN = 8'd18;

    // Byte offsets inside the device descriptor
    // Index 0 is bLength, index 1 is bDescriptorType
    localparam logic [7:0] OFS_DEVICE_CLASS = 8'd4;

    // bMaxPacketSize0, endpoint 0 only
    localparam logic [7:0] OFS_MAX_PACKET = 8'd7;

    // idVendor, little endian
    localparam logic [7:0] OFS_VENDOR_LO = 8'd8;
    localparam logic [7:0] OFS_VENDOR_HI = 8'd9;

    // idProduct, little endian
    localparam logic [7:0] OFS_PRODUCT_LO = 8'd10;
    localparam logic [7:0] OFS_PRODUCT_HI = 8'd11;

    // bNumConfigurations is the final byte of the descriptor
    localparam logic [7:0] OFS_NUM_CONFIGS = 8'd17;

endpackage

/* run_sim.sh */
#!/bin/sh
# Build the descriptor parser testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f sources.f --top-module tb_usb_desc_parser -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

if grep -q "Finished with no errors" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

/* sources.f */
+incdir+verif
hdl/usb_std_pkg.sv
hdl/desc_parser_pkg.sv
hdl/desc_byte_framer.sv
hdl/device_field_extract.sv
hdl/desc_result_reg.sv
hdl/usb_desc_parser_top.sv
verif/tb_usb_desc_parser.sv

/* verif/desc_ref_model.svh */
// Reference model and descriptor byte builders for the descriptor parser testbench
`ifndef DESC_REF_MODEL_SVH
`define DESC_REF_MODEL_SVH

typedef logic [7:0] byte_q_t[$];

// Expected result outputs after a descriptor completes
typedef struct packed {
    desc_parser_pkg::parse_status_e status;
    logic [15:0]                    vendor_id;
    logic [15:0]                    product_id;
    logic [7:0]                     device_class;
    logic [7:0]                     max_packet_size;
    logic [7:0]                     num_configurations;
    logic                           info_valid;
    logic [COUNT_WIDTH-1:0]         count;
} expect_t;

// Next expected state from the descriptor bytes and the state before them
function automatic expect_t ref_parse(input byte_q_t bytes, input expect_t prev);
    expect_t nxt;
    nxt       = prev;
    nxt.count = prev.count + 1'b1;
    if (bytes[0] < 8'd2) begin
        nxt.status = desc_parser_pkg::STATUS_BAD_LENGTH;
    end else if (bytes[1] != usb_std_pkg::DEVICE) begin
        nxt.status = desc_parser_pkg::STATUS_SKIPPED;
    end else if (bytes[0] != 8'd18) begin
        nxt.status = desc_parser_pkg::STATUS_BAD_LENGTH;
    end else begin
        // Standard device descriptor layout, multi-byte fields little endian
        nxt.status             = desc_parser_pkg::STATUS_OK;
        nxt.device_class       = bytes[4];
        nxt.max_packet_size    = bytes[7];
        nxt.vendor_id          = {bytes[9], bytes[8]};
        nxt.product_id         = {bytes[11], bytes[10]};
        nxt.num_configurations = bytes[17];
        nxt.info_valid         = 1'b1;
    end
    return nxt;
endfunction

// Descriptor of any type with random payload bytes
// A bLength below 2 still carries its type byte
function automatic void build_desc(output byte_q_t q, input logic [7:0] len,
                                   input logic [7:0] type_code);
    q = {};
    q.push_back(len);
    q.push_back(type_code);
    for (int i = 2; i < int'(len); i++) begin
        q.push_back(8'($urandom));
    end
endfunction

// Standard device descriptor with random IDs, class and configuration count
function automatic void build_device(output byte_q_t q);
    build_desc(q, 8'd18, usb_std_pkg::DEVICE);
    // bMaxPacketSize0 is one of 8, 16, 32 or 64
    q[7]  = 8'(8 << ($urandom % 4));
    q[17] = 8'(1 + $urandom % 4);
endfunction

// Malformed descriptor with bLength below 2, or a device type of the wrong length
function automatic void build_malformed(output byte_q_t q, input bit short_len);
    logic [7:0] len;
    if (short_len) begin
        build_desc(q, 8'($urandom % 2), 8'(1 + $urandom % 5));
    end else begin
        len = 8'(2 + $urandom % 40);
        if (len == 8'd18) begin
            len = 8'd19;
        end
        build_desc(q, len, usb_std_pkg::DEVICE);
    end
endfunction

`endif

/* verif/tb_usb_desc_parser.sv */
// Testbench for the USB descriptor parser with random descriptors and a reference model
`timescale 1ns/100ps

module tb_usb_desc_parser;

    localparam int COUNT_WIDTH    = 4;
    localparam int COMPLETE_LIMIT = 2000;
    localparam int MIX_COUNT      = 60;

    `include "desc_ref_model.svh"

    logic                           clk = 1'b0;
    logic                           reset = 1'b1;
    logic [7:0]                     data_in = 8'h00;
    logic                           data_valid = 1'b0;
    logic                           start_parse = 1'b0;
    logic [15:0]                    vendor_id;
    logic [15:0]                    product_id;
    logic [7:0]                     device_class;
    logic [7:0]                     max_packet_size;
    logic [7:0]                     num_configurations;
    logic                           device_info_valid;
    logic                           parsing_complete;
    desc_parser_pkg::parse_status_e parse_status;
    logic [COUNT_WIDTH-1:0]         desc_count;
    desc_parser_pkg::frame_state_e  parse_state;

    int      edge_cnt = 0;
    int      value_errors = 0;
    int      timing_errors = 0;
    int      protocol_errors = 0;
    bit      all_sent = 1'b0;
    bit      checker_done = 1'b0;
    expect_t model;
    expect_t exp_q[$];
    int      edge_q[$];

    usb_desc_parser_top #(.COUNT_WIDTH(COUNT_WIDTH)) dut_i (.*);

    always #20 clk = ~clk;

    // Rising edges since time zero, to time each completion
    always @(posedge clk) begin
        edge_cnt <= edge_cnt + 1;
    end

    task automatic check_status(input string name, input desc_parser_pkg::parse_status_e want,
                                input desc_parser_pkg::parse_status_e got);
        if (got !== want) begin
            value_errors++;
            $display("FAILED %0t %s: expected %s, got %s", $time, name, want.name(), got.name());
        end
    endtask

    task automatic check_state(input string name, input desc_parser_pkg::frame_state_e want,
                               input desc_parser_pkg::frame_state_e got);
        if (got !== want) begin
            value_errors++;
            $display("FAILED %0t %s: expected %s, got %s", $time, name, want.name(), got.name());
        end
    endtask

    task automatic check_field8(input string name, input logic [7:0] want, input logic [7:0] got);
        if (got !== want) begin
            value_errors++;
            $display("FAILED %0t %s: expected %h, got %h", $time, name, want, got);
        end
    endtask

    task automatic check_field16(input string name, input logic [15:0] want,
                                 input logic [15:0] got);
        if (got !== want) begin
            value_errors++;
            $display("FAILED %0t %s: expected %h, got %h", $time, name, want, got);
        end
    endtask

    task automatic check_flag(input string name, input logic want, input logic got);
        if (got !== want) begin
            value_errors++;
            $display("FAILED %0t %s: expected %b, got %b", $time, name, want, got);
        end
    endtask

    task automatic check_count(input string name, input logic [COUNT_WIDTH-1:0] want,
                               input logic [COUNT_WIDTH-1:0] got);
        if (got !== want) begin
            value_errors++;
            $display("FAILED %0t %s: expected %0d, got %0d", $time, name, want, got);
        end
    endtask

    task automatic check_edge(input string name, input int want, input int got);
        if (got != want) begin
            timing_errors++;
            $display("FAILED %0t %s: expected edge %0d, got edge %0d", $time, name, want, got);
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("Timeout at %0t, %s", $time, what);
        $display("Errors: value %0d, timing %0d, protocol %0d, timeout 1",
                 value_errors, timing_errors, protocol_errors);
        $display("Finished with errors");
        $finish;
    endtask

    // One descriptor, with optional idle gaps and stray start_parse inside the frame
    task automatic send_desc(input byte_q_t bytes, input bit gaps, input bit strays);
        int last_edge;
        last_edge = 0;
        foreach (bytes[i]) begin
            if (gaps) begin
                repeat ($urandom % 4) begin
                    data_valid  = 1'b0;
                    data_in     = 8'($urandom);
                    start_parse = strays && (i > 0) && ($urandom % 2 == 0);
                    @(posedge clk);
                    #2;
                end
            end
            data_valid  = 1'b1;
            data_in     = bytes[i];
            start_parse = (i == 0) || (strays && ($urandom % 2 == 0));
            // The byte is sampled at the next rising edge
            last_edge   = edge_cnt + 1;
            @(posedge clk);
            #2;
        end
        data_valid  = 1'b0;
        start_parse = 1'b0;
        model = ref_parse(bytes, model);
        exp_q.push_back(model);
        edge_q.push_back(last_edge);
    endtask

    // Compares every completion pulse with the oldest expected result
    initial begin : completion_checker
        expect_t want;
        int      want_edge;
        int      waited;
        while (!(all_sent && exp_q.size() == 0)) begin
            waited = 0;
            @(negedge clk);
            while (!parsing_complete && !(all_sent && exp_q.size() == 0)
                   && waited < COMPLETE_LIMIT) begin
                @(negedge clk);
                waited++;
            end
            if (parsing_complete && exp_q.size() == 0) begin
                protocol_errors++;
                $display("Completion pulse at %0t with no descriptor outstanding", $time);
            end else if (parsing_complete) begin
                want      = exp_q.pop_front();
                want_edge = edge_q.pop_front();
                check_edge("parsing_complete", want_edge + 3, edge_cnt);
                check_status("parse_status", want.status, parse_status);
                check_field16("vendor_id", want.vendor_id, vendor_id);
                check_field16("product_id", want.product_id, product_id);
                check_field8("device_class", want.device_class, device_class);
                check_field8("max_packet_size", want.max_packet_size, max_packet_size);
                check_field8("num_configurations", want.num_configurations, num_configurations);
                check_flag("device_info_valid", want.info_valid, device_info_valid);
                check_count("desc_count", want.count, desc_count);
                // Pulse is one cycle wide
                @(negedge clk);
                check_flag("parsing_complete", 1'b0, parsing_complete);
            end else if (!(all_sent && exp_q.size() == 0)) begin
                stop_on_timeout("no parsing_complete pulse for an outstanding descriptor");
            end
        end
        checker_done = 1'b1;
    end

    initial begin : stimulus
        byte_q_t q;
        byte_q_t dev;
        int      waited;
        void'($urandom(32'h20d6899e));
        $timeformat(-9, 1, " ns", 0);
        model = '0;
        repeat (4) @(posedge clk);
        #2;
        reset = 1'b0;
        @(negedge clk);
        check_status("parse_status", desc_parser_pkg::STATUS_NONE, parse_status);
        check_state("parse_state", desc_parser_pkg::IDLE, parse_state);
        check_field16("vendor_id", 16'h0000, vendor_id);
        check_field16("product_id", 16'h0000, product_id);
        check_field8("device_class", 8'h00, device_class);
        check_field8("max_packet_size", 8'h00, max_packet_size);
        check_field8("num_configurations", 8'h00, num_configurations);
        check_flag("device_info_valid", 1'b0, device_info_valid);
        check_flag("parsing_complete", 1'b0, parsing_complete);
        check_count("desc_count", '0, desc_count);
        @(posedge clk);
        #2;
        // A bad device length before any good one keeps device_info_valid low
        build_malformed(q, 1'b0);
        send_desc(q, 1'b0, 1'b0);
        // Same device descriptor back to back, then with gaps and stray starts
        build_device(dev);
        send_desc(dev, 1'b0, 1'b0);
        send_desc(dev, 1'b1, 1'b1);
        // Skipped types leave the latched fields alone
        build_desc(q, 8'(2 + $urandom % 30), usb_std_pkg::CONFIGURATION);
        send_desc(q, 1'b0, 1'b0);
        build_desc(q, 8'(2 + $urandom % 30), usb_std_pkg::STRING);
        send_desc(q, 1'b1, 1'b0);
        build_device(dev);
        send_desc(dev, 1'b0, 1'b0);
        // Wrong device length, then bLength 1
        build_malformed(q, 1'b0);
        send_desc(q, 1'b0, 1'b0);
        build_desc(q, 8'd1, usb_std_pkg::DEVICE);
        send_desc(q, 1'b1, 1'b1);
        // Long random mix, the counter wraps several times
        repeat (MIX_COUNT) begin
            case ($urandom % 4)
                0: build_device(q);
                1: build_desc(q, 8'(2 + $urandom % 30), usb_std_pkg::CONFIGURATION);
                2: build_desc(q, 8'(2 + $urandom % 30), usb_std_pkg::STRING);
                default: build_malformed(q, 1'($urandom % 2));
            endcase
            send_desc(q, 1'($urandom % 2), 1'($urandom % 2));
        end
        all_sent = 1'b1;
        waited   = 0;
        while (!checker_done && waited < COMPLETE_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!checker_done) begin
            stop_on_timeout("results still outstanding after the last descriptor");
        end else begin
            $display("Errors: value %0d, timing %0d, protocol %0d",
                     value_errors, timing_errors, protocol_errors);
            if (value_errors + timing_errors + protocol_errors == 0) begin
                $display("Finished with no errors");
            end else begin
                $display("Finished with errors");
            end
            $finish;
        end
    end

endmodule
